/* common/ex_pkg.sv */
// Shared types and codes for the execute stage. 32-bit datapath only.
// Opcode values outside the listed codes are treated as undefined by the ALU.
`default_nettype none

package ex_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath types
    ////////////////////////////////////////////////////////////////////////////
    typedef logic [31:0] word_t;     // Data or address word
    typedef logic [4:0]  reg_addr_t; // Register file index

    ////////////////////////////////////////////////////////////////////////////
    // ALU operation codes
    ////////////////////////////////////////////////////////////////////////////
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_ADD  = 4'd0;  // Also used for load/store address
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_SLL  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_SLT  = 4'd8;  // Signed compare
    localparam alu_op_t ALU_SLTU = 4'd9;  // Unsigned compare

    ////////////////////////////////////////////////////////////////////////////
    // Branch compare codes
    ////////////////////////////////////////////////////////////////////////////
    // LT and GE take their signedness from the separate sign input
    typedef logic [1:0] cmp_op_t;

    localparam cmp_op_t CMP_EQ = 2'd0;
    localparam cmp_op_t CMP_NE = 2'd1;
    localparam cmp_op_t CMP_LT = 2'd2;
    localparam cmp_op_t CMP_GE = 2'd3;

    ////////////////////////////////////////////////////////////////////////////
    // Load/store access size
    ////////////////////////////////////////////////////////////////////////////
    typedef logic [1:0] lsu_size_t;

    localparam lsu_size_t LSU_BYTE = 2'd0;
    localparam lsu_size_t LSU_HALF = 2'd1;
    localparam lsu_size_t LSU_WORD = 2'd2;

    // Pc increments
    localparam int INSTR_STEP      = 4;  // Full 32-bit instruction
    localparam int COMPRESSED_STEP = 2;  // 16-bit compressed instruction

    // Shifts use only the low bits of the second operand
    localparam int SHAMT_WIDTH = 5;

endpackage : ex_pkg

`default_nettype wire

/* hdl/branch_resolve.sv */
// Combinational branch/jump resolution against the fetch-time prediction.
// Redirect flags are suppressed while the instruction in EX is flushed.
`timescale 1ns/1ps
`default_nettype none

module branch_resolve import ex_pkg::*; (
    input  logic  flush,
    input  logic  branch,
    input  logic  jump,
    input  logic  compressed,      // 16-bit instruction
    input  logic  predict_taken,
    input  logic  compare_result,
    input  word_t pc,
    input  word_t src_a,           // Jump target from decode
    input  word_t src_c,           // Branch offset
    output logic  predict_fail,
    output logic  branch_taken,
    output word_t branch_target,
    output logic  jump_taken,
    output word_t jump_target,
    output word_t return_addr
);

    word_t pc_step;
    word_t pc_offset;
    logic  wrongly_taken;

    ////////////////////////////////////////////////////////////////////////////
    // Next-pc candidates
    ////////////////////////////////////////////////////////////////////////////
    assign pc_step   = compressed ? word_t'(COMPRESSED_STEP) : word_t'(INSTR_STEP);
    assign pc_offset = pc + src_c;

    assign return_addr = pc + pc_step;  // Link value for jumps

    ////////////////////////////////////////////////////////////////////////////
    // Conditional branches
    ////////////////////////////////////////////////////////////////////////////
    // Mismatch between the real outcome and the fetch prediction
    assign predict_fail = branch & (compare_result ^ predict_taken);

    assign branch_taken = predict_fail & branch & ~flush;

    // Predicted taken but falls through, so go back to the sequential pc
    assign wrongly_taken = predict_taken & ~compare_result;

    assign branch_target = wrongly_taken ? return_addr : pc_offset;

    ////////////////////////////////////////////////////////////////////////////
    // Jumps
    ////////////////////////////////////////////////////////////////////////////
    assign jump_taken  = jump & ~predict_taken & ~flush;  // Fetch did not follow it
    assign jump_target = src_a;

endmodule : branch_resolve

`default_nettype wire

/* hdl/ex_alu.sv */
// Purely combinational ALU and branch comparator.
// Undefined alu_op codes give a zero result.
`timescale 1ns/1ps
`default_nettype none

module ex_alu import ex_pkg::*; (
    input  alu_op_t alu_op,
    input  cmp_op_t cmp_op,
    input  logic    sign,           // Signed compare for CMP_LT/CMP_GE
    input  word_t   src_a,
    input  word_t   src_b,
    output word_t   alu_result,
    output logic    compare_result
);

    logic [SHAMT_WIDTH-1:0] shamt;
    logic                   equal;
    logic                   lt_signed;
    logic                   lt_unsigned;
    logic                   less_than;
    word_t                  sum;
    word_t                  diff;

    ////////////////////////////////////////////////////////////////////////////
    // Shared arithmetic
    ////////////////////////////////////////////////////////////////////////////
    assign shamt       = src_b[SHAMT_WIDTH-1:0];
    assign sum         = src_a + src_b;
    assign diff        = src_a - src_b;
    assign equal       = (src_a == src_b);
    assign lt_signed   = ($signed(src_a) < $signed(src_b));
    assign lt_unsigned = (src_a < src_b);
    assign less_than   = sign ? lt_signed : lt_unsigned;

    ////////////////////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = sum;
            ALU_SUB:  alu_result = diff;
            ALU_AND:  alu_result = src_a & src_b;
            ALU_OR:   alu_result = src_a | src_b;
            ALU_XOR:  alu_result = src_a ^ src_b;
            ALU_SLL:  alu_result = src_a << shamt;
            ALU_SRL:  alu_result = src_a >> shamt;
            ALU_SRA:  alu_result = word_t'($signed(src_a) >>> shamt);
            ALU_SLT:  alu_result = word_t'(lt_signed);
            ALU_SLTU: alu_result = word_t'(lt_unsigned);
            default:  alu_result = '0;
        endcase
    end

    // Branch condition, evaluated alongside the ALU
    always_comb begin
        case (cmp_op)
            CMP_EQ:  compare_result = equal;
            CMP_NE:  compare_result = ~equal;
            CMP_LT:  compare_result = less_than;
            CMP_GE:  compare_result = ~less_than;
            default: compare_result = 1'b0;
        endcase
    end

endmodule : ex_alu

`default_nettype wire

/* hdl/ex_mem_reg.sv */
// EX/MEM boundary register. Captures only when ready_mem is high and the
// slot is neither stalled nor flushed; ready_mem low freezes every output.
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg import ex_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    input  logic      stall,
    input  logic      flush,
    input  logic      ready_mem,
    input  word_t     pc,
    input  logic      rd_wr_en,
    input  reg_addr_t rd_wr_addr,
    input  word_t     wb_data,
    input  logic      lsu_en,
    input  logic      lsu_store,
    input  lsu_size_t lsu_size,
    input  word_t     lsu_addr,
    output word_t     pc_mem,
    output logic      rd_wr_en_mem,
    output reg_addr_t rd_wr_addr_mem,
    output word_t     rd_wr_data_mem,
    output logic      lsu_en_mem,
    output logic      lsu_store_mem,
    output lsu_size_t lsu_size_mem,
    output word_t     lsu_addr_mem,
    output word_t     lsu_wdata_mem
);

    logic bubble;
    logic capture;

    assign bubble  = stall | flush;
    assign capture = ready_mem & ~bubble;

    ////////////////////////////////////////////////////////////////////////////
    // Write-back and load/store fields
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_wr_en_mem   <= 1'b0;
            rd_wr_addr_mem <= '0;
            rd_wr_data_mem <= '0;
            lsu_en_mem     <= 1'b0;
            lsu_store_mem  <= 1'b0;
            lsu_size_mem   <= LSU_BYTE;
            lsu_addr_mem   <= '0;
        end else if (ready_mem) begin   // ready_mem low holds everything
            if (bubble) begin
                rd_wr_en_mem   <= 1'b0;
                rd_wr_addr_mem <= '0;
                rd_wr_data_mem <= '0;
                lsu_en_mem     <= 1'b0;
                lsu_store_mem  <= 1'b0;
                lsu_size_mem   <= LSU_BYTE;
                lsu_addr_mem   <= '0;
            end else begin
                rd_wr_en_mem   <= rd_wr_en;
                rd_wr_addr_mem <= rd_wr_addr;
                rd_wr_data_mem <= wb_data;
                lsu_en_mem     <= lsu_en;
                lsu_store_mem  <= lsu_store;
                lsu_size_mem   <= lsu_size;
                lsu_addr_mem   <= lsu_addr;
            end
        end
    end

    // Pc keeps its last value through bubbles
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_mem <= '0;
        end else if (capture) begin
            pc_mem <= pc;
        end
    end

    assign lsu_wdata_mem = rd_wr_data_mem;  // Store data shares the result register

endmodule : ex_mem_reg

`default_nettype wire

/* hdl/ex_stage.sv */
// Execute stage top. Redirect outputs are combinational from the *_ex inputs;
// MEM outputs appear one edge after an edge with ready_ex high.
`timescale 1ns/1ps
`default_nettype none

module ex_stage import ex_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    // Pipeline control
    input  logic      stall,
    input  logic      flush,
    input  logic      ready_mem,
    output logic      ready_ex,
    // Instruction from decode
    input  word_t     pc_ex,
    input  word_t     src_a_ex,
    input  word_t     src_b_ex,
    input  word_t     src_c_ex,
    input  alu_op_t   alu_op_ex,
    input  cmp_op_t   cmp_op_ex,
    input  logic      sign_ex,
    input  logic      branch_ex,
    input  logic      jump_ex,
    input  logic      compressed_ex,
    input  logic      predict_taken_ex,
    input  logic      rd_wr_en_ex,
    input  reg_addr_t rd_wr_addr_ex,
    input  logic      lsu_en_ex,
    input  logic      lsu_store_ex,
    input  lsu_size_t lsu_size_ex,
    // Redirect to fetch
    output logic      predict_fail,
    output logic      branch_taken,
    output word_t     branch_target,
    output logic      jump_taken,
    output word_t     jump_target,
    // Memory stage
    output word_t     pc_mem,
    output logic      rd_wr_en_mem,
    output reg_addr_t rd_wr_addr_mem,
    output word_t     rd_wr_data_mem,
    output logic      lsu_en_mem,
    output logic      lsu_store_mem,
    output lsu_size_t lsu_size_mem,
    output word_t     lsu_addr_mem,
    output word_t     lsu_wdata_mem
);

    word_t alu_result;
    word_t return_addr;
    word_t wb_data;
    logic  compare_result;

    assign ready_ex = ~stall & ready_mem;

    // Jump link, then store data, then the ALU result
    assign wb_data = jump_ex   ? return_addr :
                     lsu_en_ex ? src_c_ex    :
                                 alu_result;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath blocks
    ////////////////////////////////////////////////////////////////////////////
    ex_alu u_alu (
        .alu_op         (alu_op_ex),
        .cmp_op         (cmp_op_ex),
        .sign           (sign_ex),
        .src_a          (src_a_ex),
        .src_b          (src_b_ex),
        .alu_result     (alu_result),
        .compare_result (compare_result)
    );

    branch_resolve u_branch (
        .flush          (flush),
        .branch         (branch_ex),
        .jump           (jump_ex),
        .compressed     (compressed_ex),
        .predict_taken  (predict_taken_ex),
        .compare_result (compare_result),
        .pc             (pc_ex),
        .src_a          (src_a_ex),
        .src_c          (src_c_ex),
        .predict_fail   (predict_fail),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .jump_taken     (jump_taken),
        .jump_target    (jump_target),
        .return_addr    (return_addr)
    );

    ex_mem_reg u_ex_mem (
        .clk            (clk),
        .reset_n        (reset_n),
        .stall          (stall),
        .flush          (flush),
        .ready_mem      (ready_mem),
        .pc             (pc_ex),
        .rd_wr_en       (rd_wr_en_ex),
        .rd_wr_addr     (rd_wr_addr_ex),
        .wb_data        (wb_data),
        .lsu_en         (lsu_en_ex),
        .lsu_store      (lsu_store_ex),
        .lsu_size       (lsu_size_ex),
        .lsu_addr       (alu_result),      // Address is src_a + src_b
        .pc_mem         (pc_mem),
        .rd_wr_en_mem   (rd_wr_en_mem),
        .rd_wr_addr_mem (rd_wr_addr_mem),
        .rd_wr_data_mem (rd_wr_data_mem),
        .lsu_en_mem     (lsu_en_mem),
        .lsu_store_mem  (lsu_store_mem),
        .lsu_size_mem   (lsu_size_mem),
        .lsu_addr_mem   (lsu_addr_mem),
        .lsu_wdata_mem  (lsu_wdata_mem)
    );

endmodule : ex_stage

`default_nettype wire

/* tests/ex_stage_chk.sv */
// Concurrent checks on the EX/MEM outputs, bound into every ex_stage.
`timescale 1ns/1ps
`default_nettype none

module ex_stage_chk import ex_pkg::*; (
    input logic      clk,
    input logic      reset_n,
    input logic      ready_mem,
    input word_t     pc_mem,
    input logic      rd_wr_en_mem,
    input reg_addr_t rd_wr_addr_mem,
    input word_t     rd_wr_data_mem,
    input logic      lsu_en_mem,
    input logic      lsu_store_mem,
    input lsu_size_t lsu_size_mem,
    input word_t     lsu_addr_mem
);

    // No write-back or memory request while reset is held
    assert property (@(posedge clk) !reset_n |-> (!rd_wr_en_mem && !lsu_en_mem))
        else $error("EX/MEM enables active during reset");

    // Back-pressure freezes the whole register
    assert property (@(posedge clk) disable iff (!reset_n)
        !ready_mem |=> $stable({pc_mem, rd_wr_en_mem, rd_wr_addr_mem, rd_wr_data_mem,
                                lsu_en_mem, lsu_store_mem, lsu_size_mem, lsu_addr_mem}))
        else $error("EX/MEM outputs changed across an edge with ready_mem low");

endmodule : ex_stage_chk

bind ex_stage ex_stage_chk u_chk (.*);

`default_nettype wire

/* tests/tb_ex_stage.sv */
// Directed testbench for the execute stage. Operands come from a fixed seed.
// Redirect outputs are sampled mid-cycle, MEM outputs one edge after capture.
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage import ex_pkg::*; ();

    localparam int CLK_PERIOD      = 10;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;

    logic      clk, reset_n, stall, flush, ready_mem, ready_ex;
    word_t     pc_ex, src_a_ex, src_b_ex, src_c_ex;
    alu_op_t   alu_op_ex;
    cmp_op_t   cmp_op_ex;
    logic      sign_ex, branch_ex, jump_ex, compressed_ex, predict_taken_ex;
    logic      rd_wr_en_ex, lsu_en_ex, lsu_store_ex;
    reg_addr_t rd_wr_addr_ex, rd_wr_addr_mem;
    lsu_size_t lsu_size_ex, lsu_size_mem;
    logic      predict_fail, branch_taken, jump_taken;
    word_t     branch_target, jump_target;
    word_t     pc_mem, rd_wr_data_mem, lsu_addr_mem, lsu_wdata_mem;
    logic      rd_wr_en_mem, lsu_en_mem, lsu_store_mem;
    int        errors;
    int        checks;
    int        seed;

    ex_stage dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers and reference model
    ////////////////////////////////////////////////////////////////////////////
    task automatic expect_eq(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Idle instruction, no write-back and no memory access
    task automatic load_nop();
        stall            <= 1'b0;
        flush            <= 1'b0;
        pc_ex            <= '0;
        src_a_ex         <= '0;
        src_b_ex         <= '0;
        src_c_ex         <= '0;
        alu_op_ex        <= ALU_ADD;
        cmp_op_ex        <= CMP_EQ;
        sign_ex          <= 1'b0;
        branch_ex        <= 1'b0;
        jump_ex          <= 1'b0;
        compressed_ex    <= 1'b0;
        predict_taken_ex <= 1'b0;
        rd_wr_en_ex      <= 1'b0;
        rd_wr_addr_ex    <= '0;
        lsu_en_ex        <= 1'b0;
        lsu_store_ex     <= 1'b0;
        lsu_size_ex      <= LSU_BYTE;
    endtask

    task automatic present();      // Caller overrides fields after this
        @(posedge clk);
        load_nop();
    endtask

    task automatic capture();      // Edge that loads EX/MEM, then mid-cycle
        @(posedge clk);
        load_nop();
        @(negedge clk);
    endtask

    // Signed order by flipping the sign bit and comparing unsigned
    function automatic logic lt_model(input logic sgn, input word_t a, input word_t b);
        return sgn ? ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) : (a < b);
    endfunction

    function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b);
        int sh;
        sh = b % 32;
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            ALU_SLT:  return {31'd0, lt_model(1'b1, a, b)};
            ALU_SLTU: return {31'd0, lt_model(1'b0, a, b)};
            default:  return '0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic test_alu();
        word_t a;
        word_t b;
        // Codes above ALU_SLTU are undefined and give zero
        for (int op = 0; op < 16; op++) begin
            a = $urandom;
            b = $urandom;
            present();
            alu_op_ex     <= alu_op_t'(op);
            src_a_ex      <= a;
            src_b_ex      <= b;
            rd_wr_en_ex   <= 1'b1;
            rd_wr_addr_ex <= reg_addr_t'(op + 1);
            capture();
            expect_eq("alu result", rd_wr_data_mem, alu_model(alu_op_t'(op), a, b));
            expect_eq("rd_wr_en_mem", rd_wr_en_mem, 1'b1);
            expect_eq("rd_wr_addr_mem", rd_wr_addr_mem, op + 1);
        end
    endtask

    // Index bits: [3:2] compare code, [1] sign, [0] prediction
    task automatic test_branch();
        word_t a;
        word_t b;
        word_t pc;
        word_t off;
        logic  comp;
        logic  taken;
        for (int i = 0; i < 16; i++) begin
            a     = $urandom;
            b     = (i % 3 == 0) ? a : $urandom;  // Equal operands now and then
            pc    = $urandom & 32'hffff_fffe;
            off   = $urandom & 32'h0000_1ffe;
            comp  = $urandom_range(1, 0);
            taken = (i[3:2] == 0) ? (a == b) : (i[3:2] == 1) ? (a != b) :
                    (i[3:2] == 2) ? lt_model(i[1], a, b) : !lt_model(i[1], a, b);
            present();
            branch_ex        <= 1'b1;
            cmp_op_ex        <= cmp_op_t'(i[3:2]);
            sign_ex          <= i[1];
            predict_taken_ex <= i[0];
            compressed_ex    <= comp;
            pc_ex            <= pc;
            src_a_ex         <= a;
            src_b_ex         <= b;
            src_c_ex         <= off;
            @(negedge clk);
            expect_eq("predict_fail", predict_fail, taken ^ i[0]);
            expect_eq("branch_taken", branch_taken, taken ^ i[0]);
            expect_eq("branch_target", branch_target,
                      (i[0] && !taken) ? pc + (comp ? 2 : 4) : pc + off);
        end
    endtask

    task automatic test_jump();
        word_t pc;
        word_t tgt;
        for (int i = 0; i < 4; i++) begin
            pc  = $urandom & 32'hffff_fffe;
            tgt = $urandom & 32'hffff_fffe;
            present();
            jump_ex          <= 1'b1;
            compressed_ex    <= i[1];
            predict_taken_ex <= i[0];
            pc_ex            <= pc;
            src_a_ex         <= tgt;
            rd_wr_en_ex      <= 1'b1;
            rd_wr_addr_ex    <= 5'd1;
            @(negedge clk);
            expect_eq("jump_taken", jump_taken, !i[0]);
            expect_eq("jump_target", jump_target, tgt);
            capture();
            expect_eq("return address", rd_wr_data_mem, pc + (i[1] ? 2 : 4));
        end
    endtask

    task automatic test_lsu();
        word_t a;
        word_t b;
        word_t c;
        for (int i = 0; i < 6; i++) begin
            a = $urandom;
            b = $urandom;
            c = $urandom;
            present();
            alu_op_ex    <= ALU_ADD;
            lsu_en_ex    <= 1'b1;
            lsu_store_ex <= i[0];
            lsu_size_ex  <= lsu_size_t'(i / 2);
            rd_wr_en_ex  <= !i[0];
            src_a_ex     <= a;
            src_b_ex     <= b;
            src_c_ex     <= c;
            capture();
            expect_eq("lsu_addr_mem", lsu_addr_mem, a + b);
            expect_eq("lsu_wdata_mem", lsu_wdata_mem, c);
            expect_eq("lsu_size_mem", lsu_size_mem, i / 2);
            expect_eq("lsu_store_mem", lsu_store_mem, i[0]);
            expect_eq("lsu_en_mem", lsu_en_mem, 1'b1);
        end
    endtask

    // Pass 0 stalls, pass 1 flushes a mispredicted branch and a jump
    task automatic test_stall_flush();
        for (int i = 0; i < 2; i++) begin
            present();
            stall       <= (i == 0);
            flush       <= (i == 1);
            rd_wr_en_ex <= 1'b1;
            lsu_en_ex   <= 1'b1;
            branch_ex   <= 1'b1;
            jump_ex     <= 1'b1;
            src_a_ex    <= 32'd5;
            src_b_ex    <= 32'd5;   // CMP_EQ holds, predicted not taken
            @(negedge clk);
            expect_eq("ready_ex", ready_ex, (i == 1));
            if (i == 1) begin
                expect_eq("flushed branch_taken", branch_taken, 1'b0);
                expect_eq("flushed jump_taken", jump_taken, 1'b0);
            end
            capture();
            expect_eq("bubble rd_wr_en_mem", rd_wr_en_mem, 1'b0);
            expect_eq("bubble lsu_en_mem", lsu_en_mem, 1'b0);
        end
    endtask

    task automatic test_backpressure();
        word_t a;
        a = $urandom;
        present();
        alu_op_ex     <= ALU_XOR;
        src_a_ex      <= a;
        src_b_ex      <= 32'h5a5a_a5a5;
        rd_wr_en_ex   <= 1'b1;
        rd_wr_addr_ex <= 5'd7;
        pc_ex         <= 32'h100;
        present();                 // This edge loads the XOR
        ready_mem     <= 1'b0;
        src_a_ex      <= 32'd1;
        src_b_ex      <= 32'd2;
        rd_wr_en_ex   <= 1'b1;
        rd_wr_addr_ex <= 5'd9;
        pc_ex         <= 32'h104;
        repeat (3) begin
            @(negedge clk);
            expect_eq("ready_ex under back-pressure", ready_ex, 1'b0);
            expect_eq("held result", rd_wr_data_mem, a ^ 32'h5a5a_a5a5);
            expect_eq("held address", rd_wr_addr_mem, 5'd7);
            expect_eq("held pc", pc_mem, 32'h100);
            @(posedge clk);
        end
        ready_mem <= 1'b1;
        capture();
        expect_eq("result after release", rd_wr_data_mem, 32'd3);
        expect_eq("pc after release", pc_mem, 32'h104);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        seed      = $urandom(40645);
        errors    = 0;
        checks    = 0;
        clk       = 1'b0;
        reset_n   = 1'b0;
        ready_mem = 1'b1;
        load_nop();
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        expect_eq("reset rd_wr_data_mem", rd_wr_data_mem, 32'd0);
        expect_eq("reset lsu_addr_mem", lsu_addr_mem, 32'd0);
        test_alu();
        test_branch();
        test_jump();
        test_lsu();
        test_stall_flush();
        test_backpressure();
        @(posedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the allowed time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule : tb_ex_stage

`default_nettype wire

/* verilog.f */
common/ex_pkg.sv
hdl/ex_alu.sv
hdl/branch_resolve.sv
hdl/ex_mem_reg.sv
hdl/ex_stage.sv
tests/ex_stage_chk.sv
tests/tb_ex_stage.sv
